// ==== common/mibPkg.sv ====
// MIB counter table definitions

package mibPkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // counter RAM address, 64 entries max
  localparam int mibAddrWidth = 6;
  // one counter
  localparam int mibDataWidth = 32;
  // host or hw value, zero-extended before use
  localparam int mibValueWidth = 16;

  typedef logic [mibAddrWidth-1:0]  mibAddrT;
  typedef logic [mibDataWidth-1:0]  mibDataT;
  typedef logic [mibValueWidth-1:0] mibValueT;

  ////////////////////////////////////////
  // requester to arbiter
  ////////////////////////////////////////

  // held until grant, dropped the cycle after
  typedef struct packed {
    logic    valid;
    // 0 means read
    logic    write;
    mibAddrT addr;
    mibDataT wrData;
  } mibReqT;

  // done is a one-cycle pulse to the owner only
  typedef struct packed {
    logic    done;
    mibDataT rdData;
  } mibRspT;

  // host command, rd and wr are single-cycle pulses
  typedef struct packed {
    logic     rd;
    logic     wr;
    logic     incrementMode;
    mibAddrT  addr;
    mibValueT value;
  } mibHostCmdT;

  // MAC event, accepted only while hwReady
  typedef struct packed {
    logic     valid;
    mibAddrT  index;
    mibValueT value;
  } mibHwCmdT;

  // owner of the access in flight
  typedef enum logic [1:0] {
    ownerNone,
    ownerClear,
    ownerHost,
    ownerHw
  } mibOwnerT;

endpackage

// ==== src/mibRam.sv ====
// MIB counter RAM
`timescale 1ns/1ps

module mibRam
  import mibPkg::*;
#(
  parameter int tableDepth = 64
)
(
  input  logic    macCoreClk,
  input  logic    ramEn,
  input  logic    ramWr,
  input  mibAddrT ramAddr,
  input  mibDataT ramWrData,
  output mibDataT ramRdData
);

  // counter storage, contents undefined until a table clear
  mibDataT mem [tableDepth];

  // single port, write or read per enabled cycle
  always_ff @(posedge macCoreClk)
  begin
    if (ramEn)
    begin
      if (ramWr)
        mem[ramAddr] <= ramWrData;
      else
        // read data valid the cycle after the command
        ramRdData <= mem[ramAddr];
    end
  end

  // entries above tableDepth do not exist
  addrInRange : assert property (
    @(posedge macCoreClk) ramEn |-> (int'(ramAddr) < tableDepth)
  );

endmodule

// ==== mibArbiter/mibAccessArbiter.sv ====
// MIB RAM access arbiter
`timescale 1ns/1ps

module mibAccessArbiter
  import mibPkg::*;
(
  input  logic    macCoreClk,
  input  logic    macCoreClkHardRst_n,
  input  logic    clearing,
  input  mibReqT  clearReq,
  input  mibReqT  hostReq,
  input  mibReqT  hwReq,
  output logic    clearGnt,
  output logic    hostGnt,
  output logic    hwGnt,
  output mibRspT  clearRsp,
  output mibRspT  hostRsp,
  output mibRspT  hwRsp,
  output logic    ramEn,
  output logic    ramWr,
  output mibAddrT ramAddr,
  output mibDataT ramWrData,
  input  mibDataT ramRdData
);

  // stage 1 is the cycle the command sits at the RAM
  // stage 2 is the cycle read data and done come back
  mibOwnerT ownerS1;
  mibOwnerT ownerS2;
  logic     rdS1;
  logic     rdS2;
  // owner that keeps the port one more cycle after its read
  mibOwnerT lockQ;
  mibOwnerT lockOwner;
  mibOwnerT gntOwner;
  mibReqT   selReq;
  logic     idle;
  logic     rmwRead;
  logic     hostAllowed;
  logic     hwAllowed;

  ////////////////////////////////////////
  // grant
  ////////////////////////////////////////

  assign idle = (ownerS1 == ownerNone);

  // a host or hw read is usually the first half of a read-modify-write
  // so the same requester gets the port in the done cycle and the next
  assign rmwRead   = rdS2 && ((ownerS2 == ownerHost) || (ownerS2 == ownerHw));
  assign lockOwner = rmwRead ? ownerS2 : lockQ;

  // clearing masks host and hw
  assign hostAllowed = !clearing &&
                       ((lockOwner == ownerNone) || (lockOwner == ownerHost));
  assign hwAllowed   = !clearing &&
                       ((lockOwner == ownerNone) || (lockOwner == ownerHw));

  // priority clear, host, hw
  assign clearGnt = idle && clearReq.valid;
  assign hostGnt  = idle && !clearReq.valid && hostAllowed && hostReq.valid;
  assign hwGnt    = idle && !clearReq.valid && !hostGnt && hwAllowed && hwReq.valid;

  always_comb
  begin
    gntOwner = ownerNone;
    selReq   = '0;
    if (clearGnt)
    begin
      gntOwner = ownerClear;
      selReq   = clearReq;
    end
    else if (hostGnt)
    begin
      gntOwner = ownerHost;
      selReq   = hostReq;
    end
    else if (hwGnt)
    begin
      gntOwner = ownerHw;
      selReq   = hwReq;
    end
  end

  ////////////////////////////////////////
  // owner pipe and RAM command
  ////////////////////////////////////////

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      ownerS1 <= ownerNone;
      ownerS2 <= ownerNone;
      rdS1    <= 1'b0;
      rdS2    <= 1'b0;
      lockQ   <= ownerNone;
      ramEn   <= 1'b0;
      ramWr   <= 1'b0;
    end
    else
    begin
      ownerS1 <= gntOwner;
      rdS1    <= (gntOwner != ownerNone) && !selReq.write;
      ownerS2 <= ownerS1;
      rdS2    <= rdS1;
      // lock lasts one cycle past the done cycle
      lockQ   <= rmwRead ? ownerS2 : ownerNone;
      ramEn   <= (gntOwner != ownerNone);
      ramWr   <= selReq.write;
    end
  end

  // address and data only matter with ramEn
  always_ff @(posedge macCoreClk)
  begin
    if (gntOwner != ownerNone)
    begin
      ramAddr   <= selReq.addr;
      ramWrData <= selReq.wrData;
    end
  end

  // read data broadcast, done steers it
  assign clearRsp = '{done: (ownerS2 == ownerClear), rdData: ramRdData};
  assign hostRsp  = '{done: (ownerS2 == ownerHost),  rdData: ramRdData};
  assign hwRsp    = '{done: (ownerS2 == ownerHw),    rdData: ramRdData};

  gntOneHot : assert property (
    @(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    $onehot0({clearGnt, hostGnt, hwGnt})
  );

  // one access in flight, its done two cycles after the grant
  gntSpacing : assert property (
    @(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    (clearGnt || hostGnt || hwGnt) |=> !(clearGnt || hostGnt || hwGnt)
  );

endmodule

// ==== src/mibTableClear.sv ====
// MIB table clear sweep
`timescale 1ns/1ps

module mibTableClear
  import mibPkg::*;
#(
  parameter int tableDepth = 64
)
(
  input  logic   macCoreClk,
  input  logic   macCoreClkHardRst_n,
  input  logic   mibTableReset,
  output mibReqT clearReq,
  input  logic   clearGnt,
  input  mibRspT clearRsp,
  output logic   tableClearing,
  output logic   mibTableResetDone
);

  // last entry of the sweep
  localparam mibAddrT lastAddr = mibAddrT'(tableDepth - 1);

  mibAddrT clrAddr;
  logic    reqValid;
  logic    resetQ;
  logic    startClear;

  // rising edge of the host bit, ignored while a sweep runs
  assign startClear = mibTableReset && !resetQ && !tableClearing;

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      resetQ            <= 1'b0;
      tableClearing     <= 1'b0;
      mibTableResetDone <= 1'b0;
      reqValid          <= 1'b0;
      clrAddr           <= '0;
    end
    else
    begin
      resetQ            <= mibTableReset;
      mibTableResetDone <= 1'b0;
      if (startClear)
      begin
        tableClearing <= 1'b1;
        clrAddr       <= '0;
        reqValid      <= 1'b1;
      end
      else if (tableClearing)
      begin
        if (clearGnt)
          reqValid <= 1'b0;
        // one zero write per done, then next address
        if (clearRsp.done)
        begin
          if (clrAddr == lastAddr)
          begin
            tableClearing     <= 1'b0;
            mibTableResetDone <= 1'b1;
          end
          else
          begin
            clrAddr  <= clrAddr + mibAddrT'(1);
            reqValid <= 1'b1;
          end
        end
      end
    end
  end

  // always a write of zero
  assign clearReq = '{valid: reqValid, write: 1'b1, addr: clrAddr, wrData: '0};

endmodule

// ==== src/mibHostPort.sv ====
// MIB software access port
`timescale 1ns/1ps

module mibHostPort
  import mibPkg::*;
(
  input  logic       macCoreClk,
  input  logic       macCoreClkHardRst_n,
  input  mibHostCmdT hostCmd,
  output mibReqT     hostReq,
  input  logic       hostGnt,
  input  mibRspT     hostRsp,
  output logic       mibBusy,
  output logic       hostRdValid,
  output mibDataT    hostRdData
);

  typedef enum logic [2:0] {
    stIdle,
    stRead,
    stWrite,
    stIncRead,
    stIncWrite
  } hostStateT;

  hostStateT state;
  logic      reqValid;
  logic      reqWrite;
  mibAddrT   reqAddr;
  mibDataT   reqWrData;
  logic      cmdAccept;

  // commands only taken while idle
  assign cmdAccept = (state == stIdle) && (hostCmd.rd || hostCmd.wr);

  ////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      state       <= stIdle;
      reqValid    <= 1'b0;
      reqWrite    <= 1'b0;
      hostRdValid <= 1'b0;
    end
    else
    begin
      hostRdValid <= 1'b0;
      // drop request the cycle after grant
      if (hostGnt)
        reqValid <= 1'b0;
      case (state)
        stIdle:
        begin
          // rd wins if both pulse together
          if (hostCmd.rd)
          begin
            state    <= stRead;
            reqValid <= 1'b1;
            reqWrite <= 1'b0;
          end
          else if (hostCmd.wr)
          begin
            state    <= hostCmd.incrementMode ? stIncRead : stWrite;
            reqValid <= 1'b1;
            reqWrite <= !hostCmd.incrementMode;
          end
        end
        stRead:
          if (hostRsp.done)
          begin
            hostRdValid <= 1'b1;
            state       <= stIdle;
          end
        stIncRead:
          // write back right away, arbiter keeps the port for us
          if (hostRsp.done)
          begin
            state    <= stIncWrite;
            reqValid <= 1'b1;
            reqWrite <= 1'b1;
          end
        stWrite,
        stIncWrite:
          if (hostRsp.done)
            state <= stIdle;
        default:
          state <= stIdle;
      endcase
    end
  end

  // address, write data and read result
  always_ff @(posedge macCoreClk)
  begin
    if (cmdAccept)
    begin
      reqAddr   <= hostCmd.addr;
      // zero-extended value, also the increment operand
      reqWrData <= mibDataT'(hostCmd.value);
    end
    // sum wraps modulo 2^32
    if ((state == stIncRead) && hostRsp.done)
      reqWrData <= hostRsp.rdData + reqWrData;
    if ((state == stRead) && hostRsp.done)
      hostRdData <= hostRsp.rdData;
  end

  assign mibBusy = (state != stIdle);
  assign hostReq = '{valid: reqValid, write: reqWrite, addr: reqAddr, wrData: reqWrData};

  // host must wait for mibBusy low
  noCmdWhileBusy : assert property (
    @(posedge macCoreClk) disable iff (!macCoreClkHardRst_n)
    mibBusy |-> !(hostCmd.rd || hostCmd.wr)
  );

endmodule

// ==== src/mibHwUpdate.sv ====
// MIB hardware counter update
`timescale 1ns/1ps

module mibHwUpdate
  import mibPkg::*;
(
  input  logic     macCoreClk,
  input  logic     macCoreClkHardRst_n,
  input  mibHwCmdT hwCmd,
  output logic     hwReady,
  output mibReqT   hwReq,
  input  logic     hwGnt,
  input  mibRspT   hwRsp
);

  typedef enum logic [1:0] {
    stIdle,
    stRead,
    stWrite
  } hwStateT;

  hwStateT state;
  logic    reqValid;
  logic    reqWrite;
  mibAddrT reqAddr;
  mibDataT reqWrData;
  logic    capture;

  // one-entry capture, commands while busy are dropped
  assign capture = hwCmd.valid && hwReady;

  ////////////////////////////////////////
  // read then write back
  ////////////////////////////////////////

  always_ff @(posedge macCoreClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      state    <= stIdle;
      reqValid <= 1'b0;
      reqWrite <= 1'b0;
    end
    else
    begin
      if (hwGnt)
        reqValid <= 1'b0;
      case (state)
        stIdle:
          if (capture)
          begin
            state    <= stRead;
            reqValid <= 1'b1;
            reqWrite <= 1'b0;
          end
        stRead:
          if (hwRsp.done)
          begin
            state    <= stWrite;
            reqValid <= 1'b1;
            reqWrite <= 1'b1;
          end
        stWrite:
          // ready again once the sum is in the RAM
          if (hwRsp.done)
            state <= stIdle;
        default:
          state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge macCoreClk)
  begin
    if (capture)
    begin
      reqAddr   <= hwCmd.index;
      reqWrData <= mibDataT'(hwCmd.value);
    end
    // entry plus event value, wraps
    if ((state == stRead) && hwRsp.done)
      reqWrData <= hwRsp.rdData + reqWrData;
  end

  assign hwReady = (state == stIdle);
  assign hwReq   = '{valid: reqValid, write: reqWrite, addr: reqAddr, wrData: reqWrData};

endmodule

// ==== src/mibCounterTop.sv ====
// MIB counter table top level
`timescale 1ns/1ps

module mibCounterTop
  import mibPkg::*;
#(
  parameter int tableDepth = 64
)
(
  input  logic       macCoreClk,
  input  logic       macCoreClkHardRst_n,
  input  mibHostCmdT hostCmd,
  output logic       mibBusy,
  output logic       hostRdValid,
  output mibDataT    hostRdData,
  input  mibHwCmdT   hwCmd,
  output logic       hwReady,
  input  logic       mibTableReset,
  output logic       tableClearing,
  output logic       mibTableResetDone
);

  ////////////////////////////////////////
  // requester side
  ////////////////////////////////////////

  mibReqT  clearReq;
  mibReqT  hostReq;
  mibReqT  hwReq;
  logic    clearGnt;
  logic    hostGnt;
  logic    hwGnt;
  mibRspT  clearRsp;
  mibRspT  hostRsp;
  mibRspT  hwRsp;

  // RAM port
  logic    ramEn;
  logic    ramWr;
  mibAddrT ramAddr;
  mibDataT ramWrData;
  mibDataT ramRdData;

  mibTableClear #(
    .tableDepth (tableDepth)
  ) uTableClear (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .mibTableReset       (mibTableReset),
    .clearReq            (clearReq),
    .clearGnt            (clearGnt),
    .clearRsp            (clearRsp),
    .tableClearing       (tableClearing),
    .mibTableResetDone   (mibTableResetDone)
  );

  mibHostPort uHostPort (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .hostCmd             (hostCmd),
    .hostReq             (hostReq),
    .hostGnt             (hostGnt),
    .hostRsp             (hostRsp),
    .mibBusy             (mibBusy),
    .hostRdValid         (hostRdValid),
    .hostRdData          (hostRdData)
  );

  mibHwUpdate uHwUpdate (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .hwCmd               (hwCmd),
    .hwReady             (hwReady),
    .hwReq               (hwReq),
    .hwGnt               (hwGnt),
    .hwRsp               (hwRsp)
  );

  // clear sweep blocks host and hw through tableClearing
  mibAccessArbiter uAccessArbiter (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .clearing            (tableClearing),
    .clearReq            (clearReq),
    .hostReq             (hostReq),
    .hwReq               (hwReq),
    .clearGnt            (clearGnt),
    .hostGnt             (hostGnt),
    .hwGnt               (hwGnt),
    .clearRsp            (clearRsp),
    .hostRsp             (hostRsp),
    .hwRsp               (hwRsp),
    .ramEn               (ramEn),
    .ramWr               (ramWr),
    .ramAddr             (ramAddr),
    .ramWrData           (ramWrData),
    .ramRdData           (ramRdData)
  );

  mibRam #(
    .tableDepth (tableDepth)
  ) uRam (
    .macCoreClk (macCoreClk),
    .ramEn      (ramEn),
    .ramWr      (ramWr),
    .ramAddr    (ramAddr),
    .ramWrData  (ramWrData),
    .ramRdData  (ramRdData)
  );

endmodule

// ==== sim/mibCounterTbTasks.svh ====
// MIB testbench helpers
`ifndef MIB_COUNTER_TB_TASKS_SVH
`define MIB_COUNTER_TB_TASKS_SVH

////////////////////////////////////////
// random values
////////////////////////////////////////

logic [31:0] lcgState = 32'h1335;

// 32-bit LCG, full period
function automatic logic [31:0] lcgNext();
  lcgState = lcgState * 32'd1664525 + 32'd1013904223;
  return lcgState;
endfunction

// upper half has the better randomness
function automatic mibValueT randValue();
  logic [31:0] rnd;
  rnd = lcgNext();
  return rnd[31:16];
endfunction

////////////////////////////////////////
// reference model
////////////////////////////////////////

// mirror of the counter table
mibDataT modelMem [tbDepth];

// a clear leaves every entry at zero
function automatic void modelClear();
  foreach (modelMem[i])
    modelMem[i] = '0;
endfunction

// host write stores the value zero-extended
function automatic void modelWrite(mibAddrT addr, mibValueT value);
  modelMem[addr] = {{(mibDataWidth - mibValueWidth){1'b0}}, value};
endfunction

// increment adds the zero-extended value, wraps at 2^32
function automatic void modelAdd(mibAddrT addr, mibValueT value);
  modelMem[addr] = modelMem[addr] + {{(mibDataWidth - mibValueWidth){1'b0}}, value};
endfunction

////////////////////////////////////////
// compare tasks
////////////////////////////////////////

task automatic abortRun(string reason);
  $display("FAIL: see errors above");
  $fatal(1, "%s", reason);
endtask

task automatic checkData(string name, mibDataT actual, mibDataT expected);
  if (actual !== expected)
  begin
    $display("Error at time %0t: %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
    abortRun({"wrong value on ", name});
  end
endtask

task automatic checkBit(string name, logic actual, logic expected);
  if (actual !== expected)
  begin
    $display("Error at time %0t: %s expected %b got %b", $time, name, expected, actual);
    abortRun({"wrong level on ", name});
  end
endtask

// cycle counts and pulse counts
task automatic checkCount(string name, int actual, int expected);
  if (actual != expected)
  begin
    $display("Error at time %0t: %s expected %0d got %0d", $time, name, expected, actual);
    abortRun({"wrong count for ", name});
  end
endtask

`endif

// ==== sim/mibCounterTb.sv ====
// MIB counter table testbench
`timescale 1ns/1ps

module mibCounterTb
  import mibPkg::*;
();

  localparam int tbDepth   = 64;
  // cycles per wait before giving up
  localparam int waitLimit = 2000;

  typedef enum logic [2:0] {
    opTableReset,
    opHostRead,
    opHostWrite,
    opHostInc,
    opHwUpdate,
    opIncAndHw,
    opClearWrite
  } opT;

  // one stimulus row, reps repeats an increment
  typedef struct packed {
    opT       op;
    mibAddrT  addr;
    mibValueT value;
    mibValueT hwValue;
    int       reps;
    mibDataT  expData;
    logic     useModel;
  } stimRowT;

  logic       macCoreClk;
  logic       macCoreClkHardRst_n;
  mibHostCmdT hostCmd;
  mibHwCmdT   hwCmd;
  logic       mibTableReset;
  logic       mibBusy;
  logic       hostRdValid;
  mibDataT    hostRdData;
  logic       hwReady;
  logic       tableClearing;
  logic       mibTableResetDone;
  stimRowT    stimTable [$];

  `include "mibCounterTbTasks.svh"

  mibCounterTop #(
    .tableDepth (tbDepth)
  ) DUT (
    .macCoreClk          (macCoreClk),
    .macCoreClkHardRst_n (macCoreClkHardRst_n),
    .hostCmd             (hostCmd),
    .mibBusy             (mibBusy),
    .hostRdValid         (hostRdValid),
    .hostRdData          (hostRdData),
    .hwCmd               (hwCmd),
    .hwReady             (hwReady),
    .mibTableReset       (mibTableReset),
    .tableClearing       (tableClearing),
    .mibTableResetDone   (mibTableResetDone)
  );

  // 50 MHz
  initial
  begin
    macCoreClk = 1'b0;
    forever #10 macCoreClk = ~macCoreClk;
  end

  ////////////////////////////////////////
  // drive and wait
  ////////////////////////////////////////

  // all command inputs high for one cycle
  task automatic cmdPulse(mibHostCmdT hc, mibHwCmdT hw, logic clr);
    @(posedge macCoreClk);
    hostCmd       <= hc;
    hwCmd         <= hw;
    mibTableReset <= clr;
    @(posedge macCoreClk);
    hostCmd       <= '0;
    hwCmd         <= '0;
    mibTableReset <= 1'b0;
  endtask

  // until host and hw sequencers are both idle
  task automatic waitIdle();
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge macCoreClk);
      cycles++;
      if (cycles > waitLimit)
        abortRun("timeout waiting for host and hw sequencers to go idle");
    end
    while (mibBusy || !hwReady);
  endtask

  // latency counted from the cycle the rd pulse is seen
  task automatic waitRead(output int latency);
    latency = 0;
    do
    begin
      @(negedge macCoreClk);
      latency++;
      if (latency > waitLimit)
        abortRun("timeout waiting for hostRdValid");
      if (!hostRdValid)
        checkBit("mibBusy", mibBusy, 1'b1);
    end
    while (!hostRdValid);
  endtask

  task automatic waitClearing();
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge macCoreClk);
      cycles++;
      if (cycles > waitLimit)
        abortRun("timeout waiting for the table clear to start");
    end
    while (!tableClearing);
  endtask

  // done pulse seen and host idle, then a few cycles to catch a second pulse
  task automatic waitClearDone(output int pulses);
    int cycles;
    cycles = 0;
    pulses = 0;
    do
    begin
      @(negedge macCoreClk);
      cycles++;
      if (cycles > waitLimit)
        abortRun("timeout waiting for the table clear to finish");
      if (mibTableResetDone)
        pulses++;
    end
    while ((pulses == 0) || mibBusy);
    repeat (4)
    begin
      @(negedge macCoreClk);
      if (mibTableResetDone)
        pulses++;
    end
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  function automatic void addRow(opT op, mibAddrT addr, mibValueT value, int reps,
                                 mibDataT expData, logic useModel);
    stimRowT row;
    row.op       = op;
    row.addr     = addr;
    row.value    = value;
    // second operand for the joint host and hw row
    row.hwValue  = randValue();
    row.reps     = reps;
    row.expData  = expData;
    row.useModel = useModel;
    stimTable.push_back(row);
  endfunction

  function automatic void buildTable();
    mibValueT wrVal;
    mibValueT clrVal;
    // top bit set so a sign-extended write would show in the upper half
    wrVal  = randValue() | 16'h8000;
    clrVal = randValue();
    // clear, then spot reads of zero
    addRow(opTableReset, 6'd0, 16'h0, 1, 32'h0, 1'b0);
    addRow(opHostRead, 6'd0, 16'h0, 1, 32'h0, 1'b0);
    addRow(opHostRead, 6'd31, 16'h0, 1, 32'h0, 1'b0);
    addRow(opHostRead, mibAddrT'(tbDepth - 1), 16'h0, 1, 32'h0, 1'b0);
    // write then read back zero-extended
    addRow(opHostWrite, 6'd5, wrVal, 1, 32'h0, 1'b0);
    addRow(opHostRead, 6'd5, 16'h0, 1, {16'h0, wrVal}, 1'b0);
    addRow(opHostInc, 6'd5, randValue(), 1, 32'h0, 1'b0);
    addRow(opHostRead, 6'd5, 16'h0, 1, 32'h0, 1'b1);
    // 0xffff times 0x10001 is all ones, next increment wraps
    addRow(opHostInc, 6'd9, 16'hffff, 65537, 32'h0, 1'b0);
    addRow(opHostRead, 6'd9, 16'h0, 1, 32'hffff_ffff, 1'b0);
    addRow(opHostInc, 6'd9, randValue(), 1, 32'h0, 1'b0);
    addRow(opHostRead, 6'd9, 16'h0, 1, 32'h0, 1'b1);
    addRow(opHwUpdate, 6'd12, randValue(), 1, 32'h0, 1'b0);
    addRow(opHwUpdate, 6'd12, randValue(), 1, 32'h0, 1'b0);
    addRow(opHostRead, 6'd12, 16'h0, 1, 32'h0, 1'b1);
    // host and hw on one entry at once
    addRow(opHostWrite, 6'd20, randValue(), 1, 32'h0, 1'b0);
    addRow(opIncAndHw, 6'd20, randValue(), 1, 32'h0, 1'b0);
    addRow(opIncAndHw, 6'd20, randValue(), 1, 32'h0, 1'b0);
    addRow(opHostRead, 6'd20, 16'h0, 1, 32'h0, 1'b1);
    // write held across a clear lands after it
    addRow(opClearWrite, 6'd33, clrVal, 1, 32'h0, 1'b0);
    addRow(opHostRead, 6'd33, 16'h0, 1, {16'h0, clrVal}, 1'b0);
    addRow(opHostRead, 6'd5, 16'h0, 1, 32'h0, 1'b0);
  endfunction

  task automatic applyRow(stimRowT row);
    mibHostCmdT hc;
    mibHwCmdT   hw;
    mibDataT    expected;
    int         latency;
    int         pulses;
    hc = '0;
    hw = '0;
    case (row.op)
      opTableReset:
      begin
        cmdPulse(hc, hw, 1'b1);
        waitClearDone(pulses);
        checkCount("mibTableResetDone pulses", pulses, 1);
        checkBit("tableClearing", tableClearing, 1'b0);
        modelClear();
      end
      opHostRead:
      begin
        hc = '{rd: 1'b1, wr: 1'b0, incrementMode: 1'b0, addr: row.addr, value: '0};
        cmdPulse(hc, hw, 1'b0);
        waitRead(latency);
        checkCount("rd to hostRdValid cycles", latency, 4);
        expected = row.useModel ? modelMem[row.addr] : row.expData;
        checkData("hostRdData", hostRdData, expected);
      end
      opHostWrite:
      begin
        hc = '{rd: 1'b0, wr: 1'b1, incrementMode: 1'b0, addr: row.addr, value: row.value};
        cmdPulse(hc, hw, 1'b0);
        waitIdle();
        modelWrite(row.addr, row.value);
      end
      opHostInc:
      begin
        hc = '{rd: 1'b0, wr: 1'b1, incrementMode: 1'b1, addr: row.addr, value: row.value};
        for (int i = 0; i < row.reps; i++)
        begin
          cmdPulse(hc, hw, 1'b0);
          waitIdle();
          modelAdd(row.addr, row.value);
        end
      end
      opHwUpdate:
      begin
        hw = '{valid: 1'b1, index: row.addr, value: row.value};
        cmdPulse(hc, hw, 1'b0);
        waitIdle();
        modelAdd(row.addr, row.value);
      end
      opIncAndHw:
      begin
        hc = '{rd: 1'b0, wr: 1'b1, incrementMode: 1'b1, addr: row.addr, value: row.value};
        hw = '{valid: 1'b1, index: row.addr, value: row.hwValue};
        cmdPulse(hc, hw, 1'b0);
        waitIdle();
        modelAdd(row.addr, row.value);
        modelAdd(row.addr, row.hwValue);
      end
      opClearWrite:
      begin
        cmdPulse(hc, hw, 1'b1);
        waitClearing();
        hc = '{rd: 1'b0, wr: 1'b1, incrementMode: 1'b0, addr: row.addr, value: row.value};
        cmdPulse(hc, hw, 1'b0);
        waitClearDone(pulses);
        checkCount("mibTableResetDone pulses", pulses, 1);
        checkBit("tableClearing", tableClearing, 1'b0);
        modelClear();
        modelWrite(row.addr, row.value);
      end
      default:
        abortRun("unknown operation in the stimulus table");
    endcase
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    macCoreClkHardRst_n = 1'b0;
    hostCmd             = '0;
    hwCmd               = '0;
    mibTableReset       = 1'b0;
    buildTable();
    repeat (5) @(posedge macCoreClk);
    macCoreClkHardRst_n <= 1'b1;
    @(negedge macCoreClk);
    // idle levels out of reset
    checkBit("mibBusy", mibBusy, 1'b0);
    checkBit("hostRdValid", hostRdValid, 1'b0);
    checkBit("tableClearing", tableClearing, 1'b0);
    checkBit("mibTableResetDone", mibTableResetDone, 1'b0);
    checkBit("hwReady", hwReady, 1'b1);
    foreach (stimTable[i])
      applyRow(stimTable[i]);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== mibCounterTop.f ====
+incdir+sim
common/mibPkg.sv
src/mibRam.sv
mibArbiter/mibAccessArbiter.sv
src/mibTableClear.sv
src/mibHostPort.sv
src/mibHwUpdate.sv
src/mibCounterTop.sv
sim/mibCounterTb.sv

// ==== Makefile ====
# Verilator build and run of the MIB counter testbench

.PHONY: sim clean

# a $fatal in the testbench makes the simulator exit non-zero
sim:
	verilator --binary --timing --assert --top-module mibCounterTb -f mibCounterTop.f -o mibCounterSim
	./obj_dir/mibCounterSim

clean:
	rm -rf obj_dir
